//--- src/fdc_pkg.sv
package fdc_pkg;

	// ====================
	// widths
	// ====================
	typedef logic [1:0]  reg_addr_t;	// host register select
	typedef logic [7:0]  byte_t;
	typedef logic [19:0] img_addr_t;	// image byte address, 1 MB max
	typedef logic [10:0] len_t;		// bytes within a sector, up to 1024
	typedef logic [2:0]  size_code_t;	// fixed track geometry

	// ====================
	// host registers
	// ====================
	// command shares address 0 with status
	localparam reg_addr_t A_STATUS = 2'd0;
	localparam reg_addr_t A_TRACK  = 2'd1;
	localparam reg_addr_t A_SECTOR = 2'd2;
	localparam reg_addr_t A_DATA   = 2'd3;

	// command nibbles, upper four bits of the command byte
	localparam logic [3:0] CMD_RESTORE   = 4'h0;
	localparam logic [3:0] CMD_SEEK      = 4'h1;
	localparam logic [3:0] CMD_FORCE_INT = 4'hD;

	// ====================
	// controller states
	// ====================
	typedef enum logic [3:0] {
		IDLE,
		SEARCH,		// head settle, then sector check
		MAP,		// sector base settles, byte count loads
		READ_GAP,	// delay before the next byte
		READ_WAIT,	// drq high, host or watchdog ends the byte
		WRITE_REJECT,
		ABORT,
		WAIT,		// type I busy time
		END
	} fdc_state_t;

	// delay kinds of the shared down counter
	typedef enum logic [1:0] {TM_WAIT, TM_SETTLE, TM_GAP} timer_sel_t;

endpackage

//--- src/fdc_sector_map.sv
`timescale 1ns/1ps

module fdc_sector_map (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  fdc_pkg::size_code_t  size_code,
	input  logic                 layout,
	input  logic                 side,
	input  logic                 input_active,
	input  fdc_pkg::img_addr_t   input_addr,
	input  fdc_pkg::byte_t       disk_track,
	input  fdc_pkg::byte_t       sector,
	input  fdc_pkg::len_t        byte_offset,
	output fdc_pkg::byte_t       sectors_per_track,
	output fdc_pkg::len_t        sector_len,
	output fdc_pkg::img_addr_t   buff_addr
);

	logic [1:0] len_code;			// 128 << len_code bytes per sector
	logic active_q, layout_r;
	fdc_pkg::img_addr_t last_addr, disk_size, half, rel, base;
	fdc_pkg::byte_t ts_idx;

	always_comb begin
		case (size_code)
			3'd1:    {sectors_per_track, len_code} = {8'd16, 2'd1};
			3'd2:    {sectors_per_track, len_code} = {8'd9, 2'd2};
			3'd3:    {sectors_per_track, len_code} = {8'd5, 2'd3};
			3'd4:    {sectors_per_track, len_code} = {8'd10, 2'd2};
			3'd5:    {sectors_per_track, len_code} = {8'd18, 2'd1};
			default: {sectors_per_track, len_code} = {8'd26, 2'd0};
		endcase
	end
	assign sector_len = 11'd128 << len_code;

	// track*2+side, or plain track when sides are stored as halves
	assign ts_idx = {disk_track[6:0], side} >> layout_r;
	assign half   = (layout_r & side) ? disk_size >> 1 : '0;
	assign rel    = 20'(ts_idx) * 20'(sectors_per_track) + 20'(sector) - 20'd1;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			{active_q, layout_r} <= '0;
			disk_size <= '0;
		end else begin
			active_q <= input_active;
			if (active_q && !input_active) begin	// loader done
				disk_size <= last_addr + 20'd1;
				layout_r <= layout;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (input_active)
			last_addr <= input_addr;
		base <= half + ((rel << 7) << len_code);
	end

	assign buff_addr = base + 20'(byte_offset);

endmodule

//--- src/fdc_timer.sv
`timescale 1ns/1ps

module fdc_timer #(
	parameter int WAIT_CYCLES     = 4000,
	parameter int SETTLE_CYCLES   = 1023,
	parameter int GAP_CYCLES      = 15,
	parameter int WATCHDOG_CYCLES = 4096,
	parameter int INDEX_PERIOD    = 35000,
	parameter int INDEX_WIDTH     = 100
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 ready,
	input  logic                 timer_load,
	input  fdc_pkg::timer_sel_t  timer_sel,
	input  logic                 wd_start,
	output logic                 delay_done,
	output logic                 wd_bark,
	output logic                 index
);

	localparam int DELAY_MAX = (WAIT_CYCLES > SETTLE_CYCLES) ?
		((WAIT_CYCLES > GAP_CYCLES) ? WAIT_CYCLES : GAP_CYCLES) :
		((SETTLE_CYCLES > GAP_CYCLES) ? SETTLE_CYCLES : GAP_CYCLES);
	localparam int DW = $clog2(DELAY_MAX + 1);
	localparam int WW = $clog2(WATCHDOG_CYCLES + 1);
	localparam int IW = $clog2(INDEX_PERIOD + 1);

	logic [DW-1:0] delay_cnt;
	logic [WW-1:0] wd_cnt;
	logic [IW-1:0] index_cnt;
	logic delay_run, wd_run;

	// a load in flight masks the old count reaching zero
	assign delay_done = delay_run && delay_cnt == '0 && !timer_load;
	assign wd_bark    = wd_run && wd_cnt == '0 && !wd_start;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			{delay_run, wd_run, index} <= '0;
			delay_cnt <= '0;
			wd_cnt <= '0;
			index_cnt <= '0;
		end else begin
			if (timer_load) begin
				delay_run <= 1'b1;
				case (timer_sel)
					fdc_pkg::TM_WAIT:   delay_cnt <= DW'(WAIT_CYCLES);
					fdc_pkg::TM_SETTLE: delay_cnt <= DW'(SETTLE_CYCLES);
					default:            delay_cnt <= DW'(GAP_CYCLES);
				endcase
			end else if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1;
			else delay_run <= 1'b0;

			if (wd_start) begin
				wd_run <= 1'b1;
				wd_cnt <= WW'(WATCHDOG_CYCLES);
			end else if (wd_cnt != '0) wd_cnt <= wd_cnt - 1'b1;
			else wd_run <= 1'b0;

			// free-running index, held at zero without a disk
			if (!ready) index_cnt <= '0;
			else if (index_cnt == '0) index_cnt <= IW'(INDEX_PERIOD - 1);
			else index_cnt <= index_cnt - 1'b1;
			index <= ready && index_cnt < IW'(INDEX_WIDTH);
		end
	end

	// a pending delay is only cut short by an abort, which reloads the gap
	a_load_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		timer_load && delay_cnt != '0 |-> timer_sel == fdc_pkg::TM_GAP);

endmodule

//--- src/fdc_host_port.sv
`timescale 1ns/1ps

module fdc_host_port (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                io_en,
	input  logic                rd,
	input  logic                wr,
	input  fdc_pkg::reg_addr_t  addr,
	input  fdc_pkg::byte_t      din,
	input  fdc_pkg::byte_t      status,
	input  fdc_pkg::byte_t      track,
	input  fdc_pkg::byte_t      sector,
	input  logic                idle,
	input  fdc_pkg::byte_t      buff_din,
	output fdc_pkg::byte_t      dout,
	output logic                cmd_wr,
	output logic                track_wr,
	output logic                sector_wr,
	output fdc_pkg::byte_t      wr_byte,
	output logic                data_rd_done,
	output logic                status_rd_done,
	output fdc_pkg::byte_t      data_reg,
	output logic                data_sel
);

	logic rde, wre, old_rd, old_wr;
	logic rd_rise, wr_rise, rd_fall;
	fdc_pkg::reg_addr_t cur_addr;	// address of the access in progress

	assign rde = rd & io_en;
	assign wre = wr & io_en;
	assign rd_rise = rde & ~old_rd;
	assign wr_rise = wre & ~old_wr;
	assign rd_fall = old_rd & ~rde;

	// write pulses land on the edge that first sees wr
	assign cmd_wr    = wr_rise && addr == fdc_pkg::A_STATUS;
	assign track_wr  = wr_rise && addr == fdc_pkg::A_TRACK;
	assign sector_wr = wr_rise && addr == fdc_pkg::A_SECTOR;
	assign wr_byte   = din;

	// reads finish when rd drops
	assign data_rd_done   = rd_fall && cur_addr == fdc_pkg::A_DATA;
	assign status_rd_done = rd_fall && cur_addr == fdc_pkg::A_STATUS;

	assign data_sel = (addr == fdc_pkg::A_DATA);

	always_comb begin
		case (addr)
			fdc_pkg::A_STATUS: dout = status;
			fdc_pkg::A_TRACK:  dout = track;
			fdc_pkg::A_SECTOR: dout = sector;
			default:           dout = idle ? data_reg : buff_din;	// image byte mid-command
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			{old_rd, old_wr} <= '0;
			cur_addr <= fdc_pkg::A_STATUS;
			data_reg <= '0;
		end else begin
			old_rd <= rde;
			old_wr <= wre;
			if (rd_rise || wr_rise)
				cur_addr <= addr;
			if (wr_rise && data_sel)
				data_reg <= din;
		end
	end

endmodule

//--- src/fdc_cmd_fsm.sv
`timescale 1ns/1ps

module fdc_cmd_fsm (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 cmd_wr,
	input  fdc_pkg::byte_t       cmd_byte,
	input  logic                 track_wr,
	input  logic                 sector_wr,
	input  fdc_pkg::byte_t       wr_byte,
	input  logic                 data_rd_done,
	input  logic                 status_rd_done,
	input  fdc_pkg::byte_t       data_reg,
	input  logic                 data_sel,
	input  logic                 ready,
	input  logic                 index,
	input  logic                 delay_done,
	input  logic                 wd_bark,
	input  fdc_pkg::byte_t       sectors_per_track,
	input  fdc_pkg::len_t        sector_len,
	output fdc_pkg::byte_t       status,
	output fdc_pkg::byte_t       track,
	output fdc_pkg::byte_t       sector,
	output fdc_pkg::byte_t       disk_track,	// real head position
	output logic                 idle,
	output logic                 drq,
	output logic                 busy,
	output logic                 intrq,
	output logic                 timer_load,
	output fdc_pkg::timer_sel_t  timer_sel,
	output logic                 wd_start,
	output fdc_pkg::len_t        byte_offset,
	output logic                 buff_read
);

	fdc_pkg::fdc_state_t state;
	fdc_pkg::len_t remaining;	// bytes left in the current sector
	fdc_pkg::byte_t next_track;
	logic cmd_mode;			// 0 type I status, 1 type II
	logic s_wpe, s_headloaded, s_seekerr, s_lostdata, s_wrfault;
	logic step_dir;			// 1 steps out
	logic multisector, buff_rd;

	// explicit direction in bit 6/5, else the remembered one
	assign next_track = (cmd_byte[6] ? cmd_byte[5] : step_dir) ?
		disk_track - 8'd1 : disk_track + 8'd1;

	assign idle      = (state == fdc_pkg::IDLE);
	assign buff_read = data_sel & buff_rd;

	// crc error bit is always 0
	assign status = cmd_mode ?
		{~ready, s_wpe, s_wrfault, s_seekerr | ~ready, 1'b0, s_lostdata, drq, busy} :
		{~ready, s_wpe, s_headloaded, s_seekerr | ~ready, 1'b0,
			disk_track == 8'd0, index, busy};

	always_ff @(posedge clk_sys) begin
		timer_load <= 1'b0;
		wd_start   <= 1'b0;
		if (!rst_n) begin
			state <= fdc_pkg::IDLE;
			timer_sel <= fdc_pkg::TM_WAIT;
			{drq, busy, intrq} <= '0;
			{s_headloaded, s_seekerr, s_lostdata, s_wrfault} <= '0;
			{cmd_mode, s_wpe, step_dir, multisector, buff_rd} <= '0;
			track <= '0;
			sector <= '0;
			disk_track <= '0;
			byte_offset <= '0;
			remaining <= '0;
		end else begin
			// status read ends before the state logic can raise a new interrupt
			if (status_rd_done)
				intrq <= 1'b0;

			case (state)
				fdc_pkg::IDLE: ;
				fdc_pkg::SEARCH: if (delay_done) begin
					if (!ready || sector == 8'd0 || sector > sectors_per_track) begin
						s_seekerr <= 1'b1;
						state <= fdc_pkg::END;
					end else begin
						state <= fdc_pkg::MAP;
					end
				end
				fdc_pkg::MAP: begin
					byte_offset <= '0;
					remaining <= sector_len;
					timer_load <= 1'b1;
					timer_sel <= fdc_pkg::TM_GAP;
					state <= fdc_pkg::READ_GAP;
				end
				fdc_pkg::READ_GAP: if (delay_done) begin
					drq <= 1'b1;
					wd_start <= 1'b1;
					state <= fdc_pkg::READ_WAIT;
				end
				fdc_pkg::READ_WAIT: if (wd_bark || data_rd_done) begin
					drq <= 1'b0;
					if (wd_bark && !data_rd_done)
						s_lostdata <= 1'b1;	// sticky until the next command
					if (remaining == 11'd1) begin
						if (multisector) begin
							sector <= sector + 8'd1;
							timer_load <= 1'b1;
							timer_sel <= fdc_pkg::TM_SETTLE;
							state <= fdc_pkg::SEARCH;
						end else begin
							state <= fdc_pkg::END;
						end
					end else begin
						byte_offset <= byte_offset + 11'd1;
						remaining <= remaining - 11'd1;
						timer_load <= 1'b1;
						timer_sel <= fdc_pkg::TM_GAP;
						state <= fdc_pkg::READ_GAP;
					end
				end
				fdc_pkg::WRITE_REJECT: if (delay_done) state <= fdc_pkg::END;
				fdc_pkg::ABORT: if (delay_done) begin
					{s_seekerr, s_lostdata, s_wrfault} <= '0;
					state <= fdc_pkg::END;
				end
				fdc_pkg::WAIT: if (delay_done) begin
					busy <= 1'b0;	// type I ends here, intrq with busy low
					intrq <= 1'b1;
					state <= fdc_pkg::IDLE;
				end
				fdc_pkg::END: begin
					{drq, busy, buff_rd} <= '0;
					intrq <= 1'b1;
					state <= fdc_pkg::IDLE;
				end
				default: state <= fdc_pkg::IDLE;
			endcase

			if (track_wr && !busy)
				track <= wr_byte;
			if (sector_wr && !busy)
				sector <= wr_byte;

			// ====================
			// command decode
			// ====================
			if (cmd_wr) begin
				intrq <= 1'b0;
				if (state == fdc_pkg::IDLE || cmd_byte[7:4] == fdc_pkg::CMD_FORCE_INT) begin
					cmd_mode <= cmd_byte[7];
					s_wpe <= ~cmd_byte[7];
					case (cmd_byte[7:4])
						fdc_pkg::CMD_RESTORE, fdc_pkg::CMD_SEEK,
						4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
							if (cmd_byte[7:4] == fdc_pkg::CMD_RESTORE) begin
								track <= '0;
								disk_track <= '0;
							end else if (cmd_byte[7:4] == fdc_pkg::CMD_SEEK) begin
								track <= data_reg;
								disk_track <= data_reg;
							end else begin
								if (cmd_byte[6])
									step_dir <= cmd_byte[5];
								disk_track <= next_track;
								if (cmd_byte[4])
									track <= next_track;	// update flag
							end
							s_headloaded <= cmd_byte[3];
							busy <= 1'b1;
							timer_load <= 1'b1;
							timer_sel <= fdc_pkg::TM_WAIT;
							state <= fdc_pkg::WAIT;
						end
						4'h8, 4'h9, 4'hA, 4'hB: begin	// read / write sector, bit 5 write
							busy <= 1'b1;
							{s_seekerr, s_lostdata, s_wrfault} <= '0;
							multisector <= cmd_byte[4];
							s_wpe <= cmd_byte[5];
							timer_load <= 1'b1;
							if (cmd_byte[5]) begin
								s_wrfault <= 1'b1;	// image is read-only
								timer_sel <= fdc_pkg::TM_GAP;
								state <= fdc_pkg::WRITE_REJECT;
							end else begin
								buff_rd <= 1'b1;
								timer_sel <= fdc_pkg::TM_SETTLE;
								state <= fdc_pkg::SEARCH;
							end
						end
						fdc_pkg::CMD_FORCE_INT: begin
							cmd_mode <= 1'b0;
							drq <= 1'b0;
							if (state != fdc_pkg::IDLE) begin
								timer_load <= 1'b1;	// short gap, then END
								timer_sel <= fdc_pkg::TM_GAP;
								state <= fdc_pkg::ABORT;
							end else begin
								{s_seekerr, s_lostdata, s_wrfault, busy} <= '0;
							end
						end
						default: ;	// read address / track commands not kept
					endcase
				end
			end
		end
	end

	a_drq_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) drq |-> busy);
	a_intrq_idle: assert property (@(posedge clk_sys) disable iff (!rst_n) intrq |-> !busy);

endmodule

//--- src/fdc_top.sv
`timescale 1ns/1ps

module fdc_top #(
	parameter int WAIT_CYCLES     = 4000,
	parameter int SETTLE_CYCLES   = 1023,
	parameter int GAP_CYCLES      = 15,
	parameter int WATCHDOG_CYCLES = 4096,
	parameter int INDEX_PERIOD    = 35000,
	parameter int INDEX_WIDTH     = 100
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   io_en,
	input  logic                   rd,
	input  logic                   wr,
	input  fdc_pkg::reg_addr_t     addr,
	input  fdc_pkg::byte_t         din,
	output fdc_pkg::byte_t         dout,
	output logic                   drq,
	output logic                   intrq,
	output logic                   busy,
	input  fdc_pkg::size_code_t    size_code,
	input  logic                   layout,	// 0 track-side-sector, 1 side-track-sector
	input  logic                   side,
	input  logic                   ready,
	input  logic                   input_active,
	input  fdc_pkg::img_addr_t     input_addr,
	output fdc_pkg::img_addr_t     buff_addr,
	output logic                   buff_read,
	input  fdc_pkg::byte_t         buff_din
);

	logic cmd_wr, track_wr, sector_wr, data_rd_done, status_rd_done, data_sel;
	fdc_pkg::byte_t wr_byte, data_reg;
	fdc_pkg::byte_t status, track, sector, disk_track, sectors_per_track;
	logic idle;
	logic timer_load, wd_start, delay_done, wd_bark, index;
	fdc_pkg::timer_sel_t timer_sel;
	fdc_pkg::len_t sector_len, byte_offset;

	fdc_host_port u_host_port (
		.clk_sys, .rst_n, .io_en, .rd, .wr, .addr, .din,
		.status, .track, .sector, .idle, .buff_din,
		.dout, .cmd_wr, .track_wr, .sector_wr, .wr_byte,
		.data_rd_done, .status_rd_done, .data_reg, .data_sel
	);

	fdc_cmd_fsm u_cmd_fsm (
		.clk_sys, .rst_n, .cmd_wr,
		.cmd_byte (wr_byte),	// command byte arrives on the shared write byte
		.track_wr, .sector_wr, .wr_byte, .data_rd_done, .status_rd_done,
		.data_reg, .data_sel, .ready, .index, .delay_done, .wd_bark,
		.sectors_per_track, .sector_len,
		.status, .track, .sector, .disk_track, .idle, .drq, .busy, .intrq,
		.timer_load, .timer_sel, .wd_start, .byte_offset, .buff_read
	);

	fdc_timer #(
		.WAIT_CYCLES     (WAIT_CYCLES),
		.SETTLE_CYCLES   (SETTLE_CYCLES),
		.GAP_CYCLES      (GAP_CYCLES),
		.WATCHDOG_CYCLES (WATCHDOG_CYCLES),
		.INDEX_PERIOD    (INDEX_PERIOD),
		.INDEX_WIDTH     (INDEX_WIDTH)
	) u_timer (
		.clk_sys, .rst_n, .ready, .timer_load, .timer_sel, .wd_start,
		.delay_done, .wd_bark, .index
	);

	fdc_sector_map u_sector_map (
		.clk_sys, .rst_n, .size_code, .layout, .side, .input_active, .input_addr,
		.disk_track, .sector, .byte_offset,
		.sectors_per_track, .sector_len, .buff_addr
	);

endmodule

//--- dv/fdc_tb_tasks.svh
`ifndef FDC_TB_TASKS_SVH
`define FDC_TB_TASKS_SVH

// ====================
// host bus
// ====================
task automatic write_reg(input fdc_pkg::reg_addr_t a, input fdc_pkg::byte_t d);
	addr = a;
	din = d;
	io_en = 1'b1;
	wr = 1'b1;
	@(posedge clk_sys);
	#1;
	wr = 1'b0;
	io_en = 1'b0;
	@(posedge clk_sys);	// wr low across one edge
	#1;
endtask

task automatic read_reg(input fdc_pkg::reg_addr_t a, output fdc_pkg::byte_t d);
	addr = a;
	io_en = 1'b1;
	rd = 1'b1;
	@(posedge clk_sys);
	#1;
	d = dout;
	rd = 1'b0;
	io_en = 1'b0;
	@(posedge clk_sys);	// read completes when rd falls
	#1;
endtask

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp) begin
		errors++;
		$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		$display("=== FAIL ===");
		$fatal(1, "mismatch on %s", name);
	end
endtask

task automatic set_row(input int i, input fdc_pkg::byte_t cmd, input fdc_pkg::byte_t trk,
	input fdc_pkg::byte_t sec, input fdc_pkg::byte_t dat, input int sd, input int size,
	input int mode, input int count, input fdc_pkg::byte_t mask,
	input fdc_pkg::byte_t st, input fdc_pkg::byte_t trk_end);
	cmd_tab[i] = cmd;
	trk_tab[i] = trk;
	sec_tab[i] = sec;
	dat_tab[i] = dat;
	side_tab[i] = sd;
	size_tab[i] = size;
	mode_tab[i] = mode;
	count_tab[i] = count;
	mask_tab[i] = mask;
	status_tab[i] = st;
	track_tab[i] = trk_end;
endtask

// ====================
// image geometry
// ====================
function automatic int sectors_on_track(input int size);
	case (size)
		1: return 16;
		2: return 9;
		3: return 5;
		4: return 10;
		5: return 18;
		default: return 26;
	endcase
endfunction

function automatic int sector_bytes(input int size);
	case (size)
		1: return 256;
		2: return 512;
		3: return 1024;
		4: return 512;
		5: return 256;
		default: return 128;
	endcase
endfunction

// image byte seen by the host for one position on the disk
function automatic fdc_pkg::byte_t expected_byte(input int trk, input int sec, input int sd,
	input int size, input int offset);
	int a;
	a = (trk * sectors_on_track(size) + sec - 1) * sector_bytes(size) + offset;
	if (sd != 0)
		a = a + IMAGE_SIZE / 2;	// side 1 stored in the upper half
	return fdc_pkg::byte_t'(a[7:0] ^ a[15:8]);
endfunction

`endif

//--- dv/fdc_tb.sv
`timescale 1ns/1ps

module fdc_tb;

	// short delays keep the run small
	localparam int WAIT_CYCLES     = 20;
	localparam int SETTLE_CYCLES   = 10;
	localparam int GAP_CYCLES      = 4;
	localparam int WATCHDOG_CYCLES = 16;
	localparam int INDEX_PERIOD    = 50;
	localparam int INDEX_WIDTH     = 5;

	localparam int NUM_ROWS       = 15;
	localparam int MAX_SECTOR_LEN = 1024;
	localparam int CYCLE_LIMIT    = NUM_ROWS *
		(MAX_SECTOR_LEN * (GAP_CYCLES + 12) + WAIT_CYCLES + SETTLE_CYCLES + 200);

	localparam int IMAGE_SIZE = 'h3F000;	// side 1 starts at 0x1F800

	// host behaviour while a command runs
	localparam int HOST_READ   = 0;
	localparam int HOST_IGNORE = 1;	// drq never served
	localparam int HOST_ABORT  = 2;	// force interrupt at the first drq

	logic clk_sys, rst_n, io_en, rd, wr;
	fdc_pkg::reg_addr_t addr;
	fdc_pkg::byte_t din, dout, buff_din;
	logic drq, intrq, busy;
	fdc_pkg::size_code_t size_code;
	logic layout, side, ready, input_active, buff_read;
	fdc_pkg::img_addr_t input_addr, buff_addr;

	int errors = 0;
	int cycle_count = 0;

	// ====================
	// stimulus table
	// ====================
	fdc_pkg::byte_t cmd_tab [NUM_ROWS];
	fdc_pkg::byte_t trk_tab [NUM_ROWS];	// preset track register
	fdc_pkg::byte_t sec_tab [NUM_ROWS];
	fdc_pkg::byte_t dat_tab [NUM_ROWS];
	fdc_pkg::byte_t mask_tab [NUM_ROWS];	// status bits that are compared
	fdc_pkg::byte_t status_tab [NUM_ROWS];
	fdc_pkg::byte_t track_tab [NUM_ROWS];	// track register at the end
	int side_tab [NUM_ROWS];
	int size_tab [NUM_ROWS];
	int mode_tab [NUM_ROWS];
	int count_tab [NUM_ROWS];		// data bytes the host reads

	`include "fdc_tb_tasks.svh"

	always #4 clk_sys = ~clk_sys;

	// image RAM byte from the low and middle address bytes
	assign buff_din = buff_addr[7:0] ^ buff_addr[15:8];

	fdc_top #(
		.WAIT_CYCLES     (WAIT_CYCLES),
		.SETTLE_CYCLES   (SETTLE_CYCLES),
		.GAP_CYCLES      (GAP_CYCLES),
		.WATCHDOG_CYCLES (WATCHDOG_CYCLES),
		.INDEX_PERIOD    (INDEX_PERIOD),
		.INDEX_WIDTH     (INDEX_WIDTH)
	) DUT (
		.clk_sys, .rst_n, .io_en, .rd, .wr, .addr, .din, .dout,
		.drq, .intrq, .busy, .size_code, .layout, .side, .ready,
		.input_active, .input_addr, .buff_addr, .buff_read, .buff_din
	);

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, a command never raised intrq", cycle_count);
			$display("=== FAIL ===");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic fill_table();
		// cmd    trk    sec    dat    side size mode  bytes mask   status track
		set_row(0,  8'h00, 8'h09, 8'h01, 8'h00, 0, 0, HOST_READ, 0, 8'h15, 8'h04, 8'h00);
		set_row(1,  8'h10, 8'h00, 8'h01, 8'h05, 0, 0, HOST_READ, 0, 8'h15, 8'h00, 8'h05);
		set_row(2,  8'h50, 8'h05, 8'h01, 8'h00, 0, 0, HOST_READ, 0, 8'h15, 8'h00, 8'h06);
		set_row(3,  8'h70, 8'h06, 8'h01, 8'h00, 0, 0, HOST_READ, 0, 8'h15, 8'h00, 8'h05);
		set_row(4,  8'h30, 8'h05, 8'h01, 8'h00, 0, 0, HOST_READ, 0, 8'h15, 8'h00, 8'h04);
		set_row(5,  8'h40, 8'h04, 8'h01, 8'h00, 0, 0, HOST_READ, 0, 8'h15, 8'h00, 8'h04);
		set_row(6,  8'h10, 8'h04, 8'h01, 8'h02, 0, 0, HOST_READ, 0, 8'h15, 8'h00, 8'h02);
		set_row(7,  8'h80, 8'h02, 8'h03, 8'h00, 0, 0, HOST_READ, 128, 8'hFF, 8'h00, 8'h02);
		set_row(8,  8'h80, 8'h02, 8'h1A, 8'h00, 1, 0, HOST_READ, 128, 8'hFF, 8'h00, 8'h02);
		set_row(9,  8'h80, 8'h02, 8'h01, 8'h00, 0, 5, HOST_READ, 256, 8'hFF, 8'h00, 8'h02);
		set_row(10, 8'h80, 8'h02, 8'h12, 8'h00, 1, 5, HOST_READ, 256, 8'hFF, 8'h00, 8'h02);
		set_row(11, 8'h90, 8'h02, 8'h11, 8'h00, 0, 5, HOST_READ, 512, 8'hFF, 8'h10, 8'h02);
		set_row(12, 8'hA0, 8'h02, 8'h01, 8'h00, 0, 0, HOST_READ, 0, 8'h3F, 8'h20, 8'h02);
		set_row(13, 8'h80, 8'h02, 8'h01, 8'h00, 1, 0, HOST_IGNORE, 0, 8'hFF, 8'h04, 8'h02);
		set_row(14, 8'h80, 8'h02, 8'h02, 8'h00, 0, 0, HOST_ABORT, 0, 8'h15, 8'h00, 8'h02);
	endtask

	task automatic load_image();
		input_addr = fdc_pkg::img_addr_t'(IMAGE_SIZE - 1);
		input_active = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		input_active = 1'b0;	// falling edge captures size and layout
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	// presets, command, then serve the host side until intrq
	task automatic run_row(input int i);
		fdc_pkg::byte_t value;
		int got;
		int len;
		bit aborted;
		got = 0;
		aborted = 1'b0;
		len = sector_bytes(size_tab[i]);
		side = (side_tab[i] != 0);
		size_code = fdc_pkg::size_code_t'(size_tab[i]);
		write_reg(fdc_pkg::A_TRACK, trk_tab[i]);
		write_reg(fdc_pkg::A_SECTOR, sec_tab[i]);
		write_reg(fdc_pkg::A_DATA, dat_tab[i]);
		write_reg(fdc_pkg::A_STATUS, cmd_tab[i]);
		check_value("busy", 32'(busy), 32'd1);
		while (intrq !== 1'b1) begin
			if (drq === 1'b1 && mode_tab[i] == HOST_READ) begin
				read_reg(fdc_pkg::A_DATA, value);
				check_value("buff_read", 32'(buff_read), 32'd1);
				check_value("dout", 32'(value), 32'(expected_byte(int'(track_tab[i]),
					int'(sec_tab[i]) + got / len, side_tab[i], size_tab[i], got % len)));
				got++;
			end else if (drq === 1'b1 && mode_tab[i] == HOST_ABORT && !aborted) begin
				write_reg(fdc_pkg::A_STATUS, {fdc_pkg::CMD_FORCE_INT, 4'h0});
				aborted = 1'b1;
			end else begin
				@(posedge clk_sys);
				#1;
			end
		end
		check_value("busy", 32'(busy), 32'd0);	// falls together with intrq
		check_value("drq", 32'(drq), 32'd0);
		check_value("byte count", 32'(got), 32'(count_tab[i]));
		read_reg(fdc_pkg::A_DATA, value);	// data register again while idle
		check_value("data", 32'(value), 32'(dat_tab[i]));
		check_value("buff_read", 32'(buff_read), 32'd0);
		read_reg(fdc_pkg::A_STATUS, value);
		check_value("status", 32'(value & mask_tab[i]), 32'(status_tab[i]));
		check_value("intrq", 32'(intrq), 32'd0);	// cleared by the status read
		read_reg(fdc_pkg::A_TRACK, value);
		check_value("track", 32'(value), 32'(track_tab[i]));
		$display("row %0d done at %0t ns", i, $time);
	endtask

	initial begin
		clk_sys = 1'b0;
		rst_n = 1'b0;
		{io_en, rd, wr} = '0;
		addr = fdc_pkg::A_STATUS;
		din = '0;
		size_code = '0;
		layout = 1'b1;	// side-track-sector image
		side = 1'b0;
		ready = 1'b1;
		input_active = 1'b0;
		input_addr = '0;
		fill_table();
		repeat (4) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		load_image();
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		if (errors == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "%0d checks failed", errors);
		end
	end

endmodule

//--- fdc_top.f
+incdir+dv
src/fdc_pkg.sv
src/fdc_sector_map.sv
src/fdc_timer.sv
src/fdc_host_port.sv
src/fdc_cmd_fsm.sv
src/fdc_top.sv
dv/fdc_tb.sv

//--- Makefile
# Verilator build and run of the fdc testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module fdc_tb -f fdc_top.f -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vfdc_tb

clean:
	rm -rf $(OBJ_DIR)
